/* hw/alu_defs.svh */
// ******************************
// Default width 5, at least 2 and at most 8 since
// the flags start at bit 8 of the RESULT word
// APB offsets are 4-bit, one 32-bit word each
// ******************************
`ifndef ALU_DEFS_SVH
`define ALU_DEFS_SVH

`define ALU_WIDTH         5

`define ALU_ADDR_A        4'h0
`define ALU_ADDR_B        4'h4
`define ALU_ADDR_CTRL     4'h8
`define ALU_ADDR_RESULT   4'hC

`define ALU_RES_FLAGS_LSB 8
`define ALU_FLAG_COUNT    6

`endif

/* hw/alu_pkg.sv */
// ******************************
// Operation codes match bits 2..0 of CTRL
// Flag order is fixed by the RESULT word layout
// ******************************
package alu_pkg;

    typedef enum logic [2:0] {
        OP_ADD = 3'd0,  // A + B
        OP_SUB = 3'd1,  // A - B
        OP_NOT = 3'd2,  // ~A
        OP_AND = 3'd3,
        OP_OR  = 3'd4,
        OP_NEG = 3'd5,  // Two's complement of A
        OP_INC = 3'd6,
        OP_DEC = 3'd7
    } alu_op_e;

    // Comparison flags look at A and B, the rest at the result
    typedef struct packed {
        logic equal;
        logic greater;  // Signed A > B
        logic less;     // Signed A < B
        logic zero;
        logic carry;    // Borrow on SUB and DEC
        logic overflow; // Signed overflow
    } alu_flags_t;

endpackage

/* hw/alu_if.sv */
// ******************************
// Clock and reset only serve the core's checks
// ******************************
`include "alu_defs.svh"

interface alu_if (
    input logic clk,
    input logic reset
);
    import alu_pkg::*;

    logic [`ALU_WIDTH-1:0] a;
    logic [`ALU_WIDTH-1:0] b;
    alu_op_e               op;
    logic [`ALU_WIDTH-1:0] result;
    alu_flags_t            flags;

    modport regs (
        output a, b, op,
        input  result, flags
    );

    modport core (
        input  clk, reset,
        input  a, b, op,
        output result, flags
    );

endinterface

/* hw/alu_ripple_addsub.sv */
// ******************************
// Plain ripple chain, delay grows with width
// carry is a borrow when subtract is high
// ******************************
`include "alu_defs.svh"

module alu_ripple_addsub (
    input  logic [`ALU_WIDTH-1:0] a,
    input  logic [`ALU_WIDTH-1:0] b,
    input  logic                  subtract,
    output logic [`ALU_WIDTH-1:0] sum,
    output logic                  carry
);
    logic [`ALU_WIDTH-1:0] b_eff;
    logic [`ALU_WIDTH:0]   c;

    assign b_eff = b ^ {`ALU_WIDTH{subtract}}; // One's complement for subtract
    assign c[0]  = subtract;                   // Plus one completes the negation

    for (genvar i = 0; i < `ALU_WIDTH; i++) begin : g_bit
        logic p;

        assign p        = a[i] ^ b_eff[i];
        assign sum[i]   = p ^ c[i];
        assign c[i + 1] = (a[i] & b_eff[i]) | (p & c[i]);
    end

    // No carry out of A + ~B + 1 means A < B unsigned
    assign carry = c[`ALU_WIDTH] ^ subtract;

endmodule

/* hw/alu_core.sv */
// ******************************
// Purely combinational, no latency
// Carry only on ADD, SUB, INC, DEC
// Overflow only on ADD, SUB, NEG, INC, DEC
// Compare flags are signed
// ******************************
`include "alu_defs.svh"

module alu_core (
    alu_if.core bus
);
    import alu_pkg::*;

    localparam int MSB = `ALU_WIDTH - 1;

    logic [MSB:0] main_a;
    logic [MSB:0] main_b;
    logic         main_sub;
    logic [MSB:0] main_sum;
    logic         main_carry;
    logic         main_ovf;

    logic [MSB:0] step_one;
    logic         step_sub;
    logic [MSB:0] step_sum;
    logic         step_carry;
    logic         step_ovf;

    logic [MSB:0] result;
    logic         carry;
    logic         overflow;
    alu_flags_t   flags;

    // Signed overflow of x +/- y from the sign bits alone
    function automatic logic signed_ovf(
        input logic x_msb,
        input logic y_msb,
        input logic sub,
        input logic r_msb
    );
        return (x_msb ~^ (y_msb ^ sub)) & (r_msb ^ x_msb);
    endfunction

    // NEG is computed as 0 - A
    assign main_sub = (bus.op == OP_SUB) || (bus.op == OP_NEG);
    assign main_a   = (bus.op == OP_NEG) ? '0 : bus.a;
    assign main_b   = (bus.op == OP_NEG) ? bus.a : bus.b;

    alu_ripple_addsub u_main (
        .a        (main_a),
        .b        (main_b),
        .subtract (main_sub),
        .sum      (main_sum),
        .carry    (main_carry)
    );

    assign step_one = {{MSB{1'b0}}, 1'b1};
    assign step_sub = (bus.op == OP_DEC);

    alu_ripple_addsub u_step (
        .a        (bus.a),
        .b        (step_one),
        .subtract (step_sub),
        .sum      (step_sum),
        .carry    (step_carry)
    );

    assign main_ovf = signed_ovf(main_a[MSB], main_b[MSB], main_sub, main_sum[MSB]);
    assign step_ovf = signed_ovf(bus.a[MSB], step_one[MSB], step_sub, step_sum[MSB]);

    always_comb begin
        result   = main_sum;
        carry    = 1'b0;
        overflow = 1'b0;
        case (bus.op)
            OP_ADD, OP_SUB: begin
                result   = main_sum;
                carry    = main_carry;
                overflow = main_ovf;
            end
            OP_NOT: result = ~bus.a;
            OP_AND: result = bus.a & bus.b;
            OP_OR:  result = bus.a | bus.b;
            OP_NEG: begin
                result   = main_sum;
                overflow = main_ovf; // Only for the most negative A
            end
            OP_INC, OP_DEC: begin
                result   = step_sum;
                carry    = step_carry;
                overflow = step_ovf;
            end
            default: result = main_sum;
        endcase
    end

    assign flags.equal    = (bus.a == bus.b);
    assign flags.greater  = ($signed(bus.a) > $signed(bus.b));
    assign flags.less     = ($signed(bus.a) < $signed(bus.b));
    assign flags.zero     = ~|result;
    assign flags.carry    = carry;
    assign flags.overflow = overflow;

    assign bus.result = result;
    assign bus.flags  = flags;

    // On SUB exactly one compare flag follows the sign of the difference
    a_cmp_onehot: assert property (
        @(posedge bus.clk) disable iff (bus.reset)
        (bus.op == OP_SUB) |->
            ({bus.flags.equal, bus.flags.greater, bus.flags.less} ==
             {main_sum == '0,
              (main_sum != '0) && !(main_sum[MSB] ^ main_ovf),
              main_sum[MSB] ^ main_ovf})
    );

    // NEG gives zero only for A of zero, NOT only for A of all ones
    a_zero_match: assert property (
        @(posedge bus.clk) disable iff (bus.reset)
        (bus.op == OP_NEG || bus.op == OP_NOT) |->
            (bus.flags.zero == ((bus.op == OP_NEG) ? (bus.a == '0) : (&bus.a)))
    );

endmodule

/* hw/alu_apb_regs.sv */
// ******************************
// APB3 slave, no wait states, pready tied high
// RESULT loads one cycle after a CTRL write
// pslverr on bad address or RESULT write
// ******************************
`include "alu_defs.svh"

module alu_apb_regs (
    input  logic        clk,
    input  logic        reset,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [3:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    alu_if.regs         bus
);
    import alu_pkg::*;

    logic                  access;
    logic                  addr_hit;
    logic                  hit_result;
    logic                  wr_en;
    logic                  capture;
    logic [31:0]           rd_word;

    logic [`ALU_WIDTH-1:0] a_q;
    logic [`ALU_WIDTH-1:0] b_q;
    alu_op_e               op_q;
    logic [`ALU_WIDTH-1:0] res_q;
    alu_flags_t            flags_q;

    assign access = psel & penable;

    // Decode and read mux, misaligned offsets fall to default
    always_comb begin
        addr_hit = 1'b1;
        rd_word  = '0;
        case (paddr)
            `ALU_ADDR_A:    rd_word[`ALU_WIDTH-1:0] = a_q;
            `ALU_ADDR_B:    rd_word[`ALU_WIDTH-1:0] = b_q;
            `ALU_ADDR_CTRL: rd_word[2:0] = op_q;
            `ALU_ADDR_RESULT: begin
                rd_word[`ALU_WIDTH-1:0] = res_q;
                rd_word[`ALU_RES_FLAGS_LSB +: `ALU_FLAG_COUNT] = flags_q;
            end
            default: addr_hit = 1'b0;
        endcase
    end

    assign hit_result = (paddr == `ALU_ADDR_RESULT);
    assign pslverr    = access & (~addr_hit | (pwrite & hit_result));
    assign wr_en      = access & pwrite & ~pslverr;
    assign pready     = 1'b1;
    assign prdata     = (access & ~pwrite & ~pslverr) ? rd_word : '0; // Failed read gives zero

    always_ff @(posedge clk) begin
        if (reset) begin
            a_q     <= '0;
            b_q     <= '0;
            op_q    <= OP_ADD;
            capture <= 1'b0;
            res_q   <= '0;
            flags_q <= '0;
        end else begin
            if (wr_en) begin
                case (paddr)
                    `ALU_ADDR_A:    a_q  <= pwdata[`ALU_WIDTH-1:0];
                    `ALU_ADDR_B:    b_q  <= pwdata[`ALU_WIDTH-1:0];
                    `ALU_ADDR_CTRL: op_q <= alu_op_e'(pwdata[2:0]);
                    default:        op_q <= op_q;
                endcase
            end
            capture <= wr_en & (paddr == `ALU_ADDR_CTRL); // Core sees new op next cycle
            if (capture) begin
                res_q   <= bus.result;
                flags_q <= bus.flags;
            end
        end
    end

    assign bus.a  = a_q;
    assign bus.b  = b_q;
    assign bus.op = op_q;

    // Access cycle must come straight after a setup cycle
    a_apb_setup_first: assert property (
        @(posedge clk) disable iff (reset)
        (psel && penable) |-> $past(psel && !penable)
    );

    // Address and direction held from setup into access
    a_apb_ctrl_stable: assert property (
        @(posedge clk) disable iff (reset)
        (psel && penable) |-> ($stable(paddr) && $stable(pwrite))
    );

endmodule

/* hw/alu_apb_top.sv */
// ******************************
// APB3 slave at the pins, clk is pclk
// No interrupts, one master only
// ******************************
module alu_apb_top (
    input  logic        clk,
    input  logic        reset,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [3:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr
);

    alu_if bus (
        .clk   (clk),
        .reset (reset)
    );

    alu_apb_regs u_regs (
        .clk     (clk),
        .reset   (reset),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .bus     (bus.regs)
    );

    alu_core u_core (
        .bus (bus.core)
    );

endmodule

/* testbench/tb_alu_apb.sv */
// ******************************
// Expects pready high and no wait states
// All aligned offsets are mapped, so error
// cases use misaligned offsets and RESULT writes
// ******************************
`include "alu_defs.svh"

module tb_alu_apb;
    import alu_pkg::*;

    localparam int W              = `ALU_WIDTH;
    localparam int N_RANDOM       = 300;
    localparam int TRANSFERS      = 4 + 8 * 25 * 4 + N_RANDOM * 4 + 9 + 10;
    localparam int TIMEOUT_CYCLES = 6 * TRANSFERS + 100;

    logic         clk = 1'b0;
    logic         reset;
    logic         psel;
    logic         penable;
    logic         pwrite;
    logic [3:0]   paddr;
    logic [31:0]  pwdata;
    logic [31:0]  prdata;
    logic         pready;
    logic         pslverr;

    logic [15:0]  lfsr_state = 16'd19155;
    int           cycle_count = 0;
    logic [W-1:0] corner [5];

    // Register contents the DUT should hold
    logic [W-1:0] exp_a;
    logic [W-1:0] exp_b;
    logic [2:0]   exp_op;
    logic [31:0]  exp_res_word;

    alu_apb_top u_alu_apb_top (
        .clk     (clk),
        .reset   (reset),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            end_with_failure();
        end
    end

    task automatic end_with_failure();
        $display("test failed");
        $fatal(1, "stopped at first failure");
    endtask

    // Taps 16, 14, 13, 11
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_bit()};
        end
        return v;
    endfunction

    // Integer arithmetic, then range checks for carry and overflow
    function automatic void model_alu(
        input  logic [W-1:0] a,
        input  logic [W-1:0] b,
        input  alu_op_e      op,
        output logic [W-1:0] res,
        output alu_flags_t   flags
    );
        int   ua;
        int   ub;
        int   sa;
        int   sb;
        int   full;
        int   sfull;
        logic signed_op;
        ua        = a;
        ub        = b;
        sa        = a[W-1] ? ua - (1 << W) : ua;
        sb        = b[W-1] ? ub - (1 << W) : ub;
        full      = 0;
        sfull     = 0;
        signed_op = 1'b1;
        flags     = '0;
        case (op)
            OP_ADD: begin
                full        = ua + ub;
                sfull       = sa + sb;
                flags.carry = (full >= (1 << W));
            end
            OP_SUB: begin
                full        = ua - ub;
                sfull       = sa - sb;
                flags.carry = (ua < ub); // Borrow
            end
            OP_NEG: begin
                full  = -ua;
                sfull = -sa;
            end
            OP_INC: begin
                full        = ua + 1;
                sfull       = sa + 1;
                flags.carry = (full >= (1 << W));
            end
            OP_DEC: begin
                full        = ua - 1;
                sfull       = sa - 1;
                flags.carry = (ua == 0);
            end
            default: begin
                signed_op = 1'b0;
                if (op == OP_NOT) full = ~ua;
                else if (op == OP_AND) full = ua & ub;
                else full = ua | ub;
            end
        endcase
        res            = full[W-1:0];
        flags.overflow = signed_op &&
                         (sfull < -(1 << (W - 1)) || sfull > (1 << (W - 1)) - 1);
        flags.equal    = (ua == ub);
        flags.greater  = (sa > sb);
        flags.less     = (sa < sb);
        flags.zero     = (res == '0);
    endfunction

    function automatic logic [31:0] pack_result(input logic [W-1:0] res, input alu_flags_t f);
        logic [31:0] w;
        w = '0;
        w[W-1:0] = res;
        w[`ALU_RES_FLAGS_LSB +: `ALU_FLAG_COUNT] = f;
        return w;
    endfunction

    task automatic check_result(input string name, input logic [W-1:0] expected,
                                input logic [W-1:0] actual);
        if (actual !== expected) begin
            $display("error at %0t: %s expected %h, got %h", $time, name, expected, actual);
            end_with_failure();
        end
    endtask

    task automatic check_flags(input string name, input alu_flags_t expected,
                               input alu_flags_t actual);
        if (actual !== expected) begin
            $display("error at %0t: %s expected %b, got %b", $time, name, expected, actual);
            end_with_failure();
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            $display("error at %0t: %s expected %h, got %h", $time, name, expected, actual);
            end_with_failure();
        end
    endtask

    task automatic apb_write(input logic [3:0] addr, input logic [31:0] data,
                             input logic expect_err);
        @(posedge clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(negedge clk); // Mid access cycle
        check_word("pready", 32'd1, {31'd0, pready});
        check_word("pslverr", {31'd0, expect_err}, {31'd0, pslverr});
        @(posedge clk); // Write lands here
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_read(input logic [3:0] addr, input logic expect_err,
                            output logic [31:0] data);
        @(posedge clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(negedge clk);
        check_word("pready", 32'd1, {31'd0, pready});
        check_word("pslverr", {31'd0, expect_err}, {31'd0, pslverr});
        data = prdata;
        if (expect_err) check_word("prdata on error", 32'd0, data);
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic check_regs();
        logic [31:0] word;
        apb_read(`ALU_ADDR_A, 1'b0, word);
        check_word("prdata A", 32'(exp_a), word);
        apb_read(`ALU_ADDR_B, 1'b0, word);
        check_word("prdata B", 32'(exp_b), word);
        apb_read(`ALU_ADDR_CTRL, 1'b0, word);
        check_word("prdata CTRL", 32'(exp_op), word);
        apb_read(`ALU_ADDR_RESULT, 1'b0, word);
        check_word("prdata RESULT", exp_res_word, word);
    endtask

    task automatic run_op(input logic [W-1:0] a, input logic [W-1:0] b, input alu_op_e op);
        logic [31:0]  word;
        logic [W-1:0] m_res;
        alu_flags_t   m_flags;
        apb_write(`ALU_ADDR_A, 32'(a), 1'b0);
        apb_write(`ALU_ADDR_B, 32'(b), 1'b0);
        apb_write(`ALU_ADDR_CTRL, 32'(op), 1'b0);
        model_alu(a, b, op, m_res, m_flags);
        apb_read(`ALU_ADDR_RESULT, 1'b0, word);
        check_result("result", m_res, word[W-1:0]);
        check_flags("flags", m_flags, word[`ALU_RES_FLAGS_LSB +: `ALU_FLAG_COUNT]);
        exp_a        = a;
        exp_b        = b;
        exp_op       = op;
        exp_res_word = pack_result(m_res, m_flags);
    endtask

    task automatic readback_and_capture();
        logic [31:0]  wa;
        logic [31:0]  wb;
        logic [31:0]  wc;
        logic [31:0]  word;
        logic [W-1:0] m_res;
        alu_flags_t   m_flags;
        wa = rand_bits(32);
        wb = rand_bits(32);
        wc = rand_bits(32);
        apb_write(`ALU_ADDR_A, wa, 1'b0);
        apb_write(`ALU_ADDR_B, wb, 1'b0);
        apb_write(`ALU_ADDR_CTRL, wc, 1'b0);
        exp_a  = wa[W-1:0];
        exp_b  = wb[W-1:0];
        exp_op = wc[2:0];
        model_alu(exp_a, exp_b, alu_op_e'(exp_op), m_res, m_flags);
        exp_res_word = pack_result(m_res, m_flags);
        check_regs();
        apb_write(`ALU_ADDR_A, ~wa, 1'b0); // No CTRL write, RESULT must hold
        exp_a = ~wa[W-1:0];
        apb_read(`ALU_ADDR_RESULT, 1'b0, word);
        check_word("prdata RESULT after A rewrite", exp_res_word, word);
    endtask

    task automatic error_responses();
        logic [31:0] word;
        apb_write(4'h2, rand_bits(32), 1'b1);
        apb_write(4'h5, rand_bits(32), 1'b1);
        apb_write(4'hB, rand_bits(32), 1'b1);
        apb_write(`ALU_ADDR_RESULT, rand_bits(32), 1'b1);
        apb_read(4'h1, 1'b1, word);
        apb_read(4'hE, 1'b1, word);
        check_regs();
    endtask

    initial begin
        reset   = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        corner[0] = W'(0);
        corner[1] = W'(1);
        corner[2] = W'(15);
        corner[3] = W'(16);
        corner[4] = W'(31);
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;

        exp_a        = '0;
        exp_b        = '0;
        exp_op       = '0;
        exp_res_word = '0;
        check_regs();

        // Every corner pair, equal pairs included
        for (int k = 0; k < 8; k++) begin
            for (int i = 0; i < 5; i++) begin
                for (int j = 0; j < 5; j++) begin
                    run_op(corner[i], corner[j], alu_op_e'(k));
                end
            end
        end

        for (int n = 0; n < N_RANDOM; n++) begin
            logic [31:0] ra;
            logic [31:0] rb;
            logic [31:0] ro;
            ra = rand_bits(W);
            rb = rand_bits(W);
            ro = rand_bits(3);
            run_op(ra[W-1:0], rb[W-1:0], alu_op_e'(ro[2:0]));
        end

        readback_and_capture();
        error_responses();

        $display("test passed");
        $finish;
    end

endmodule

/* compile.f */
+incdir+hw
hw/alu_pkg.sv
hw/alu_if.sv
hw/alu_ripple_addsub.sv
hw/alu_core.sv
hw/alu_apb_regs.sv
hw/alu_apb_top.sv
testbench/tb_alu_apb.sv

/* Bender.yml */
package:
  name: alu_apb

export_include_dirs:
  - hw

sources:
  - files:
      - hw/alu_pkg.sv
      - hw/alu_if.sv
      - hw/alu_ripple_addsub.sv
      - hw/alu_core.sv
      - hw/alu_apb_regs.sv
      - hw/alu_apb_top.sv
  - target: test
    files:
      - testbench/tb_alu_apb.sv
